// ==== hdl/mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int NB_OP  = 6;
    localparam int NB_REG = 5;

    localparam logic [NB_OP-1:0] OP_RTYPE = 6'b000000;
    localparam logic [NB_OP-1:0] OP_LW    = 6'b100011;
    localparam logic [NB_OP-1:0] OP_LH    = 6'b100001;
    localparam logic [NB_OP-1:0] OP_LHU   = 6'b100101;
    localparam logic [NB_OP-1:0] OP_LB    = 6'b100000;
    localparam logic [NB_OP-1:0] OP_LBU   = 6'b100100;
    localparam logic [NB_OP-1:0] OP_LWU   = 6'b100111;
    localparam logic [NB_OP-1:0] OP_SW    = 6'b101011;
    localparam logic [NB_OP-1:0] OP_SH    = 6'b101001;
    localparam logic [NB_OP-1:0] OP_SB    = 6'b101000;
    localparam logic [NB_OP-1:0] OP_ADDI  = 6'b001000;
    localparam logic [NB_OP-1:0] OP_ORI   = 6'b001101;
    localparam logic [NB_OP-1:0] OP_XORI  = 6'b001110;
    localparam logic [NB_OP-1:0] OP_LUI   = 6'b001111;
    localparam logic [NB_OP-1:0] OP_SLTI  = 6'b001010;
    localparam logic [NB_OP-1:0] OP_BEQ   = 6'b000100;
    localparam logic [NB_OP-1:0] OP_BNE   = 6'b000101;
    localparam logic [NB_OP-1:0] OP_J     = 6'b000010;
    localparam logic [NB_OP-1:0] OP_JAL   = 6'b000011;

    localparam logic [NB_OP-1:0] FN_ADDU = 6'b100001;
    localparam logic [NB_OP-1:0] FN_SUBU = 6'b100011;
    localparam logic [NB_OP-1:0] FN_AND  = 6'b100100;
    localparam logic [NB_OP-1:0] FN_OR   = 6'b100101;
    localparam logic [NB_OP-1:0] FN_XOR  = 6'b100110;
    localparam logic [NB_OP-1:0] FN_SLT  = 6'b101010;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
    } alu_op_e;

    // matches opcode[1:0] of the load/store group
    typedef enum logic [1:0] {
        W_BYTE = 2'b00,
        W_HALF = 2'b01,
        W_WORD = 2'b11
    } width_e;

    typedef enum logic [1:0] {
        PC_SEQ, PC_BRANCH, PC_JUMP
    } pc_sel_e;

    typedef enum logic [2:0] {
        ST_FETCH   = 3'd0,
        ST_DECODE  = 3'd1,
        ST_EXECUTE = 3'd2,
        ST_MEM     = 3'd3,
        ST_WB      = 3'd4
    } ctrl_state_e;

endpackage

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  mips_pkg::alu_op_e         i_op,
    input  logic [mips_pkg::XLEN-1:0] i_a,
    input  logic [mips_pkg::XLEN-1:0] i_b,
    output logic [mips_pkg::XLEN-1:0] o_result,
    output logic                      o_zero
);
    import mips_pkg::*;

    logic lt;

    assign lt = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;    // also the branch compare
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_SLT: o_result = {{(XLEN-1){1'b0}}, lt};
            ALU_LUI: o_result = {i_b[15:0], 16'h0000};
            default: o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_we,
    input  logic [mips_pkg::NB_REG-1:0] i_waddr,
    input  logic [mips_pkg::XLEN-1:0]   i_wdata,
    input  logic [mips_pkg::NB_REG-1:0] i_raddr_a,
    input  logic [mips_pkg::NB_REG-1:0] i_raddr_b,
    output logic [mips_pkg::XLEN-1:0]   o_rdata_a,
    output logic [mips_pkg::XLEN-1:0]   o_rdata_b
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [2**NB_REG];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**NB_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = regs[i_raddr_a];
    assign o_rdata_b = regs[i_raddr_b];

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_pc_we,
    input  logic                        i_ir_we,
    input  mips_pkg::pc_sel_e           i_pc_sel,
    input  logic [mips_pkg::XLEN-1:0]   i_instr,
    output logic [mips_pkg::XLEN-1:0]   o_pc,
    output logic [mips_pkg::NB_OP-1:0]  o_opcode,
    output logic [mips_pkg::NB_OP-1:0]  o_funct,
    output logic [mips_pkg::NB_REG-1:0] o_rs,
    output logic [mips_pkg::NB_REG-1:0] o_rt,
    output logic [mips_pkg::NB_REG-1:0] o_rd,
    output logic [15:0]                 o_imm
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc, ir, pc_next;

    // pc already points past the current instruction here
    always_comb begin
        case (i_pc_sel)
            PC_BRANCH: pc_next = pc + {{(XLEN-18){ir[15]}}, ir[15:0], 2'b00};
            PC_JUMP:   pc_next = {pc[31:28], ir[25:0], 2'b00};
            default:   pc_next = pc + XLEN'(4);
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= '0;
            ir <= '0;                             // decodes as a no-op
        end else begin
            if (i_pc_we) begin
                pc <= pc_next;
            end
            if (i_ir_we) begin
                ir <= i_instr;
            end
        end
    end

    assign o_pc     = pc;
    assign o_opcode = ir[31:26];
    assign o_rs     = ir[25:21];
    assign o_rt     = ir[20:16];
    assign o_rd     = ir[15:11];
    assign o_funct  = ir[5:0];
    assign o_imm    = ir[15:0];

endmodule

// ==== hdl/mem_align.sv ====
`timescale 1ns/1ps

module mem_align (
    input  mips_pkg::width_e          i_width,
    input  logic                      i_unsigned,
    input  logic [1:0]                i_addr_lo,
    input  logic [mips_pkg::XLEN-1:0] i_store_data,
    input  logic [mips_pkg::XLEN-1:0] i_bus_rdata,
    output logic [mips_pkg::XLEN-1:0] o_bus_wdata,
    output logic [3:0]                o_bus_sel,
    output logic [mips_pkg::XLEN-1:0] o_load_data
);
    import mips_pkg::*;

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    logic        ext_bit;

    // little endian, lane 0 is bits 7:0
    always_comb begin
        case (i_width)
            W_BYTE: begin
                o_bus_wdata = {4{i_store_data[7:0]}};
                o_bus_sel   = 4'b0001 << i_addr_lo;
            end
            W_HALF: begin
                o_bus_wdata = {2{i_store_data[15:0]}};
                o_bus_sel   = i_addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                o_bus_wdata = i_store_data;
                o_bus_sel   = 4'b1111;
            end
        endcase
    end

    assign lane_byte = i_bus_rdata[8*i_addr_lo +: 8];
    assign lane_half = i_addr_lo[1] ? i_bus_rdata[31:16] : i_bus_rdata[15:0];

    always_comb begin
        case (i_width)
            W_BYTE: begin
                ext_bit     = ~i_unsigned & lane_byte[7];
                o_load_data = {{(XLEN-8){ext_bit}}, lane_byte};
            end
            W_HALF: begin
                ext_bit     = ~i_unsigned & lane_half[15];
                o_load_data = {{(XLEN-16){ext_bit}}, lane_half};
            end
            default: begin
                ext_bit     = 1'b0;               // full word, nothing to extend
                o_load_data = i_bus_rdata;
            end
        endcase
    end

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic [mips_pkg::NB_OP-1:0] i_opcode,
    input  logic [mips_pkg::NB_OP-1:0] i_funct,
    input  logic                       i_alu_zero,
    input  logic                       i_wb_ack,
    output mips_pkg::ctrl_state_e      o_state,
    output logic                       o_pc_we,
    output logic                       o_ir_we,
    output mips_pkg::pc_sel_e          o_pc_sel,
    output logic                       o_rf_we,
    output logic                       o_rf_wsel,      // 1 = rd, 0 = rt
    output logic                       o_rf_link,      // r31 <- return address
    output mips_pkg::alu_op_e          o_alu_op,
    output logic                       o_alu_src_imm,
    output logic                       o_imm_zero_ext,
    output mips_pkg::width_e           o_mem_width,
    output logic                       o_mem_unsigned,
    output logic                       o_wb_cyc,
    output logic                       o_wb_stb,
    output logic                       o_wb_we,
    output logic                       o_adr_data
);
    import mips_pkg::*;

    ctrl_state_e state, next_state;
    logic        wb_cyc, wb_we;
    logic        bus_done;
    logic        br_taken;
    width_e      dec_width;
    logic        dec_rf_we, dec_load, dec_store;
    logic        dec_branch, dec_bne, dec_jump;

    always_comb begin
        o_alu_op       = ALU_ADD;
        o_alu_src_imm  = 1'b0;
        o_imm_zero_ext = 1'b0;
        o_mem_unsigned = 1'b0;
        o_rf_wsel      = 1'b0;
        o_rf_link      = 1'b0;
        dec_width      = W_WORD;
        dec_rf_we      = 1'b0;
        dec_load       = 1'b0;
        dec_store      = 1'b0;
        dec_branch     = 1'b0;
        dec_bne        = 1'b0;
        dec_jump       = 1'b0;

        case (i_opcode)
            OP_RTYPE: begin
                o_rf_wsel = 1'b1;
                dec_rf_we = 1'b1;
                case (i_funct)
                    FN_ADDU: o_alu_op = ALU_ADD;
                    FN_SUBU: o_alu_op = ALU_SUB;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_XOR:  o_alu_op = ALU_XOR;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    default: dec_rf_we = 1'b0;   // unsupported funct, no-op
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
                o_alu_src_imm  = 1'b1;
                dec_rf_we      = 1'b1;
                dec_load       = 1'b1;
                dec_width      = width_e'(i_opcode[1:0]);
                o_mem_unsigned = i_opcode[2];     // the ...u forms
            end
            OP_SB, OP_SH, OP_SW: begin
                o_alu_src_imm = 1'b1;
                dec_store     = 1'b1;
                dec_width     = width_e'(i_opcode[1:0]);
            end
            OP_ADDI: begin
                o_alu_src_imm = 1'b1;
                dec_rf_we     = 1'b1;
            end
            OP_ORI: begin
                o_alu_src_imm  = 1'b1;
                o_imm_zero_ext = 1'b1;
                o_alu_op       = ALU_OR;
                dec_rf_we      = 1'b1;
            end
            OP_XORI: begin
                o_alu_src_imm  = 1'b1;
                o_imm_zero_ext = 1'b1;
                o_alu_op       = ALU_XOR;
                dec_rf_we      = 1'b1;
            end
            OP_LUI: begin
                o_alu_src_imm = 1'b1;
                o_alu_op      = ALU_LUI;
                dec_rf_we     = 1'b1;
            end
            OP_SLTI: begin
                o_alu_src_imm = 1'b1;
                o_alu_op      = ALU_SLT;
                dec_rf_we     = 1'b1;
            end
            OP_BEQ: begin
                o_alu_op   = ALU_SUB;
                dec_branch = 1'b1;
            end
            OP_BNE: begin
                o_alu_op   = ALU_SUB;
                dec_branch = 1'b1;
                dec_bne    = 1'b1;
            end
            OP_J: begin
                dec_jump = 1'b1;
            end
            OP_JAL: begin
                dec_jump  = 1'b1;
                o_rf_link = 1'b1;
            end
            default: ;                            // unknown opcode, no-op
        endcase
    end

    assign bus_done = wb_cyc & i_wb_ack;
    assign br_taken = dec_branch & (dec_bne ? ~i_alu_zero : i_alu_zero);

    always_comb begin
        next_state = state;
        o_pc_we    = 1'b0;
        o_ir_we    = 1'b0;
        o_pc_sel   = PC_SEQ;
        o_rf_we    = 1'b0;

        case (state)
            ST_FETCH: begin
                o_ir_we = bus_done;
                o_pc_we = bus_done;
                if (bus_done) begin
                    next_state = ST_DECODE;
                end
            end
            ST_DECODE: begin
                o_pc_sel   = PC_JUMP;
                o_pc_we    = dec_jump;
                o_rf_we    = o_rf_link;
                next_state = ST_EXECUTE;
            end
            ST_EXECUTE: begin
                o_pc_sel = PC_BRANCH;
                o_pc_we  = br_taken;
                if (dec_load || dec_store) begin
                    next_state = ST_MEM;
                end else if (dec_rf_we) begin
                    next_state = ST_WB;
                end else begin
                    next_state = ST_FETCH;
                end
            end
            ST_MEM: begin
                // load data is only valid alongside ack
                o_rf_we = bus_done & dec_load;
                if (bus_done) begin
                    next_state = dec_load ? ST_WB : ST_FETCH;
                end
            end
            ST_WB: begin
                o_rf_we    = dec_rf_we & ~dec_load;
                next_state = ST_FETCH;
            end
            default: next_state = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= ST_FETCH;
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            state  <= next_state;
            // bus goes idle for a cycle after every ack
            wb_cyc <= ((next_state == ST_FETCH) || (next_state == ST_MEM)) && !bus_done;
            wb_we  <= (next_state == ST_MEM) && dec_store;
        end
    end

    assign o_state     = state;
    assign o_wb_cyc    = wb_cyc;
    assign o_wb_stb    = wb_cyc;                  // single transfers only
    assign o_wb_we     = wb_we;
    assign o_adr_data  = (state == ST_MEM);
    assign o_mem_width = (state == ST_MEM) ? dec_width : W_WORD;  // fetch is a word

endmodule

// ==== hdl/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
    input  logic                      clk,
    input  logic                      i_rst_n,
    output logic                      o_wb_cyc,
    output logic                      o_wb_stb,
    output logic                      o_wb_we,
    output logic [mips_pkg::XLEN-1:0] o_wb_adr,
    output logic [mips_pkg::XLEN-1:0] o_wb_dat,
    output logic [3:0]                o_wb_sel,
    input  logic [mips_pkg::XLEN-1:0] i_wb_dat,
    input  logic                      i_wb_ack
);
    import mips_pkg::*;

    logic              pc_we, ir_we, rf_we, rf_wsel, rf_link;
    logic              alu_src_imm, imm_zero_ext, mem_unsigned, adr_data;
    pc_sel_e           pc_sel;
    alu_op_e           alu_op;
    width_e            mem_width;
    logic [NB_OP-1:0]  opcode, funct;
    logic [NB_REG-1:0] rs, rt, rd;
    logic [15:0]       imm;
    logic [XLEN-1:0]   pc, rdata_a, rdata_b, alu_result, load_data;
    logic              alu_zero;

    control_unit u_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_opcode       (opcode),
        .i_funct        (funct),
        .i_alu_zero     (alu_zero),
        .i_wb_ack       (i_wb_ack),
        .o_state        (),                       // observed by the bus checks only
        .o_pc_we        (pc_we),
        .o_ir_we        (ir_we),
        .o_pc_sel       (pc_sel),
        .o_rf_we        (rf_we),
        .o_rf_wsel      (rf_wsel),
        .o_rf_link      (rf_link),
        .o_alu_op       (alu_op),
        .o_alu_src_imm  (alu_src_imm),
        .o_imm_zero_ext (imm_zero_ext),
        .o_mem_width    (mem_width),
        .o_mem_unsigned (mem_unsigned),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_we        (o_wb_we),
        .o_adr_data     (adr_data)
    );

    fetch_unit u_fetch (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_pc_we  (pc_we),
        .i_ir_we  (ir_we),
        .i_pc_sel (pc_sel),
        .i_instr  (i_wb_dat),
        .o_pc     (pc),
        .o_opcode (opcode),
        .o_funct  (funct),
        .o_rs     (rs),
        .o_rt     (rt),
        .o_rd     (rd),
        .o_imm    (imm)
    );

    // pc already holds the return address when jal writes r31
    reg_file u_rf (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_we      (rf_we),
        .i_waddr   (rf_link ? NB_REG'(31) : (rf_wsel ? rd : rt)),
        .i_wdata   (rf_link ? pc : (adr_data ? load_data : alu_result)),
        .i_raddr_a (rs),
        .i_raddr_b (rt),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b)
    );

    alu u_alu (
        .i_op     (alu_op),
        .i_a      (rdata_a),
        .i_b      (alu_src_imm ? (imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm})
                               : rdata_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    mem_align u_align (
        .i_width      (mem_width),
        .i_unsigned   (mem_unsigned),
        .i_addr_lo    (o_wb_adr[1:0]),
        .i_store_data (rdata_b),
        .i_bus_rdata  (i_wb_dat),
        .o_bus_wdata  (o_wb_dat),
        .o_bus_sel    (o_wb_sel),
        .o_load_data  (load_data)
    );

    assign o_wb_adr = adr_data ? alu_result : pc;

endmodule

// ==== tests/mips_core_props.sv ====
`timescale 1ns/1ps

module mips_core_props (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  mips_pkg::ctrl_state_e i_state,
    input  logic                  i_cyc,
    input  logic                  i_stb,
    input  logic                  i_we,
    input  logic                  i_ack,
    input  logic                  i_adr_data,
    input  mips_pkg::width_e      i_width
);
    import mips_pkg::*;

    int n_fail = 0;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_stb |-> (i_cyc && (i_state == ST_FETCH || i_state == ST_MEM)))
        else begin
            $error("stb raised without cyc or outside a bus state");
            n_fail++;
        end

    // address source, width and we decide adr, sel and dat
    hold_until_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_stb && !i_ack) |=> ($stable(i_we) && $stable(i_adr_data)
                               && $stable(i_width) && $stable(i_state)))
        else begin
            $error("bus request changed before ack");
            n_fail++;
        end

    drop_after_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_stb && i_ack) |=> (!i_stb && !i_cyc))
        else begin
            $error("cyc or stb still high on the edge after ack");
            n_fail++;
        end

    idle_in_reset: assert property (@(posedge clk) !i_rst_n |-> !i_cyc)
        else begin
            $error("cyc high during reset");
            n_fail++;
        end

    no_fetch_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_state == ST_FETCH) |-> !(i_stb && i_we))
        else begin
            $error("write strobe in fetch state");
            n_fail++;
        end

endmodule

bind control_unit mips_core_props u_props (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_state    (o_state),
    .i_cyc      (o_wb_cyc),
    .i_stb      (o_wb_stb),
    .i_we       (o_wb_we),
    .i_ack      (i_wb_ack),
    .i_adr_data (o_adr_data),
    .i_width    (o_mem_width)
);

// ==== tests/tb_wb_ram.sv ====
`timescale 1ns/1ps

module tb_wb_ram (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_cyc,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [31:0] i_adr,
    input  logic [31:0] i_dat,
    input  logic [3:0]  i_sel,
    input  logic [1:0]  i_wait,
    input  logic        i_load,
    input  logic [31:0] i_image [256],
    output logic [31:0] o_dat,
    output logic        o_ack
);
    logic [31:0] mem      [256];
    logic [3:0]  last_sel [256];
    logic [1:0]  cnt;
    logic [7:0]  widx;
    logic        hit;

    assign widx = i_adr[9:2];
    assign hit  = i_cyc & i_stb & ~o_ack & (cnt == i_wait);   // last wait state done

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
            cnt   <= 2'd0;
            o_dat <= '0;
        end else begin
            o_ack <= hit;
            if (hit) begin
                cnt   <= 2'd0;
                o_dat <= mem[widx];
            end else if (i_cyc && i_stb && !o_ack) begin
                cnt <= cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= i_image[i];                         // whole image at once
            end
        end else if (hit && i_we) begin
            for (int b = 0; b < 4; b++) begin
                if (i_sel[b]) begin
                    mem[widx][8*b +: 8] <= i_dat[8*b +: 8];
                end
            end
            last_sel[widx] <= i_sel;
        end
    end

endmodule

// ==== tests/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;
    import mips_pkg::*;

    logic        clk, rst_n, cyc, stb, we, ack, ld_we;
    logic [31:0] adr, dat_w, dat_r;
    logic [3:0]  sel;
    logic [1:0]  wait_n = 2'd0;
    logic [8:0]  wait_idx = 9'd0;
    logic [1:0]  wait_tab [512];
    logic [31:0] lfsr = 32'h45de_236d;
    logic [31:0] img [256];
    logic [31:0] a, b, p0, p1;
    string       exp_name [$];
    int          exp_idx [$];
    logic [31:0] exp_val [$];
    int          n_code, slot, n_err, jal_at, cycles;
    bit          timed_out;

    mips_core uut (
        .clk(clk), .i_rst_n(rst_n), .o_wb_cyc(cyc), .o_wb_stb(stb), .o_wb_we(we),
        .o_wb_adr(adr), .o_wb_dat(dat_w), .o_wb_sel(sel), .i_wb_dat(dat_r), .i_wb_ack(ack)
    );

    tb_wb_ram u_ram (
        .clk(clk), .i_rst_n(rst_n), .i_cyc(cyc), .i_stb(stb), .i_we(we), .i_adr(adr),
        .i_dat(dat_w), .i_sel(sel), .i_wait(wait_n), .i_load(ld_we), .i_image(img),
        .o_dat(dat_r), .o_ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // new wait count for the next transfer
    always @(negedge clk) begin
        if (ack) begin
            wait_n   <= wait_tab[wait_idx];
            wait_idx <= wait_idx + 9'd1;
        end
    end

    function automatic logic [31:0] draw_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] rtype_word(logic [5:0] fn, logic [4:0] rs, rt, rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(logic [5:0] op, logic [4:0] rs, rt,
                                               logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(logic [5:0] op, int idx);
        return {op, 26'(idx)};
    endfunction

    function automatic logic [31:0] fill_word(int idx);
        return 32'hbad0_0000 + 32'(idx);
    endfunction

    function automatic logic [31:0] sext16(logic [15:0] x);
        return {{16{x[15]}}, x};
    endfunction

    function automatic logic [31:0] lane_value(logic [31:0] w, int off, int nb, bit sgn);
        logic [31:0] s;
        s = w >> (8 * off);
        if (nb == 1) return sgn ? {{24{s[7]}}, s[7:0]} : {24'h0, s[7:0]};
        if (nb == 2) return sgn ? sext16(s[15:0]) : {16'h0, s[15:0]};
        return w;
    endfunction

    task automatic put(logic [31:0] word);
        img[n_code] = word;
        n_code++;
    endtask

    task automatic expect_word(string name, int idx, logic [31:0] val);
        exp_name.push_back(name);
        exp_idx.push_back(idx);
        exp_val.push_back(val);
    endtask

    // results go to 0x300 + 4*slot through r2
    task automatic slot_store(string name, logic [4:0] src, logic [31:0] val);
        put(itype_word(OP_SW, 5'd2, src, 16'(4 * slot)));
        expect_word(name, 192 + slot, val);
        slot++;
    endtask

    task automatic alu_case(string name, logic [31:0] word, logic [31:0] val);
        put(word);
        slot_store(name, 5'd5, val);
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] val);
        assert (got === val) else begin
            $display("FAIL %s expected %h actual %h", name, val, got);
            n_err++;
        end
    endtask

    initial begin
        rst_n  = 1'b0;
        ld_we  = 1'b0;
        n_code = 0;
        slot   = 0;
        n_err  = 0;
        for (int i = 0; i < 512; i++) wait_tab[i] = 2'(draw_bits(2));
        for (int i = 0; i < 256; i++) img[i] = fill_word(i);
        a  = draw_bits(32);
        b  = draw_bits(32);
        if (b == a) b = ~a;
        p0 = draw_bits(32);
        p1 = draw_bits(32);
        img[128] = a;
        img[129] = b;
        img[160] = p0;
        img[161] = p1;

        put(itype_word(OP_ORI, 0, 1, 16'h0200));                // operand base
        put(itype_word(OP_ORI, 0, 2, 16'h0300));                // result base
        put(itype_word(OP_ORI, 0, 6, 16'h0280));
        put(itype_word(OP_ORI, 0, 7, 16'h0077));                // marker value
        put(itype_word(OP_LW, 1, 3, 16'd0));
        put(itype_word(OP_LW, 1, 4, 16'd4));

        alu_case("addu", rtype_word(FN_ADDU, 3, 4, 5), a + b);
        alu_case("subu", rtype_word(FN_SUBU, 3, 4, 5), a - b);
        alu_case("and", rtype_word(FN_AND, 3, 4, 5), a & b);
        alu_case("or", rtype_word(FN_OR, 3, 4, 5), a | b);
        alu_case("xor", rtype_word(FN_XOR, 3, 4, 5), a ^ b);
        alu_case("slt", rtype_word(FN_SLT, 3, 4, 5), ($signed(a) < $signed(b)) ? 1 : 0);
        alu_case("addi", itype_word(OP_ADDI, 3, 5, 16'h8123), a + sext16(16'h8123));
        alu_case("ori", itype_word(OP_ORI, 3, 5, 16'h8123), a | 32'h8123);
        alu_case("xori", itype_word(OP_XORI, 3, 5, 16'h9c5a), a ^ 32'h9c5a);
        alu_case("lui", itype_word(OP_LUI, 0, 5, 16'ha5c3), 32'ha5c3_0000);
        alu_case("slti_neg", itype_word(OP_SLTI, 3, 5, 16'h8001),
                 ($signed(a) < $signed(sext16(16'h8001))) ? 1 : 0);
        alu_case("slti_pos", itype_word(OP_SLTI, 3, 5, 16'h7fff),
                 ($signed(a) < 32'sh7fff) ? 1 : 0);

        for (int off = 0; off < 4; off++) begin
            alu_case($sformatf("lb_%0d", off), itype_word(OP_LB, 1, 5, 16'(off)),
                     lane_value(a, off, 1, 1));
            alu_case($sformatf("lbu_%0d", off), itype_word(OP_LBU, 1, 5, 16'(off)),
                     lane_value(a, off, 1, 0));
        end
        for (int off = 0; off < 4; off += 2) begin
            alu_case($sformatf("lh_%0d", off), itype_word(OP_LH, 1, 5, 16'(off)),
                     lane_value(a, off, 2, 1));
            alu_case($sformatf("lhu_%0d", off), itype_word(OP_LHU, 1, 5, 16'(off)),
                     lane_value(a, off, 2, 0));
        end
        alu_case("lw", itype_word(OP_LW, 1, 5, 16'd0), a);
        alu_case("lwu", itype_word(OP_LWU, 1, 5, 16'd0), a);

        put(itype_word(OP_SB, 6, 3, 16'd1));
        put(itype_word(OP_SH, 6, 3, 16'd6));
        expect_word("sb_lane", 160, {p0[31:16], a[7:0], p0[7:0]});
        expect_word("sh_lane", 161, {a[15:0], p1[15:0]});

        put(itype_word(OP_BEQ, 3, 3, 16'd1));
        slot_store("beq_taken_skip", 7, fill_word(192 + slot));
        slot_store("beq_taken_path", 7, 32'h77);
        put(itype_word(OP_BEQ, 3, 4, 16'd1));
        slot_store("beq_not_taken", 7, 32'h77);
        put(itype_word(OP_BNE, 3, 4, 16'd1));
        slot_store("bne_taken_skip", 7, fill_word(192 + slot));
        slot_store("bne_taken_path", 7, 32'h77);
        put(itype_word(OP_BNE, 3, 3, 16'd1));
        slot_store("bne_not_taken", 7, 32'h77);
        put(jump_word(OP_J, n_code + 2));
        slot_store("j_skip", 7, fill_word(192 + slot));
        jal_at = n_code;
        put(jump_word(OP_JAL, n_code + 2));
        slot_store("jal_skip", 7, fill_word(192 + slot));
        slot_store("jal_link", 31, 32'(4 * jal_at + 4));

        put(itype_word(OP_ORI, 0, 8, 16'h03fc));
        put(itype_word(OP_SW, 8, 7, 16'd0));                    // end marker
        put(jump_word(OP_J, n_code));                           // park here

        // image is copied on the first edge, inside the reset window
        ld_we = 1'b1;
        @(negedge clk);
        ld_we = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        cycles = 0;
        while (u_ram.mem[255] !== 32'h77 && cycles < 20000) begin
            @(negedge clk);
            cycles++;
        end
        timed_out = (u_ram.mem[255] !== 32'h77);
        if (timed_out) begin
            $display("timeout: the end marker was not stored within %0d cycles", cycles);
        end else begin
            for (int i = 0; i < exp_name.size(); i++) begin
                check_word(exp_name[i], u_ram.mem[exp_idx[i]], exp_val[i]);
            end
            check_word("sb_sel", 32'(u_ram.last_sel[160]), 32'h2);
            check_word("sh_sel", 32'(u_ram.last_sel[161]), 32'hc);
        end

        $display("errors: %0d value, %0d protocol, %0d timeout",
                 n_err, uut.u_ctrl.u_props.n_fail, timed_out);
        if (n_err == 0 && !timed_out && uut.u_ctrl.u_props.n_fail == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== mips_core.f ====
hdl/mips_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/mem_align.sv
hdl/control_unit.sv
hdl/mips_core.sv
tests/mips_core_props.sv
tests/tb_wb_ram.sv
tests/tb_mips_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f mips_core.f --top-module tb_mips_core -o tb_mips_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mips_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0
